// File: Makefile
# Verilator flow for the serial bus system

VERILATOR ?= verilator
TOP ?= tb_bus_top
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_MSG ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/bus_arbiter.sv
// bus arbiter
// fixed priority for master 1, the owner keeps its grant until its transfer ends

`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input wire clk,
	input wire rst_n,
	input wire m1_request,
	input wire m2_request,
	input wire m1_trans_done,
	input wire m2_trans_done,
	output logic m1_grant,
	output logic m2_grant
);

	typedef enum logic [1:0] {
		own_none,
		own_m1,
		own_m2
	} owner_t;

	owner_t owner;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner <= own_none;
		end else begin
			case (owner)
				own_m1: if (m1_trans_done) owner <= own_none;
				own_m2: if (m2_trans_done) owner <= own_none;
				default: begin
					if (m1_request)
						owner <= own_m1; // master 1 wins a tie
					else if (m2_request)
						owner <= own_m2;
				end
			endcase
		end
	end

	// one owner at a time, so never both grants
	assign m1_grant = (owner == own_m1);
	assign m2_grant = (owner == own_m2);

endmodule

`default_nettype wire

// File: hdl/bus_interconnect.sv
// bus interconnect
// puts the granted master's serial lines on the selected slave and
// returns that slave's lines to the granted master only

`timescale 1ns/1ns
`default_nettype none

module bus_interconnect import bus_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire m1_request, m1_master_valid, m1_master_ready, m1_trans_done,
	input wire m1_tx_address, m1_tx_data, m1_write_en, m1_read_en,
	input wire slave_sel_t m1_slave_sel,
	input wire m2_request, m2_master_valid, m2_master_ready, m2_trans_done,
	input wire m2_tx_address, m2_tx_data, m2_write_en, m2_read_en,
	input wire slave_sel_t m2_slave_sel,
	input wire s1_slave_ready, s1_slave_valid, s1_tx_data,
	input wire s2_slave_ready, s2_slave_valid, s2_tx_data,
	input wire s3_slave_ready, s3_slave_valid, s3_tx_data,
	output logic m1_grant, m2_grant,
	output logic m1_slave_ready, m1_slave_valid, m1_rx_data,
	output logic m2_slave_ready, m2_slave_valid, m2_rx_data,
	output logic s1_master_valid, s1_master_ready, s1_rx_address,
	output logic s1_rx_data, s1_write_en, s1_read_en,
	output logic s2_master_valid, s2_master_ready, s2_rx_address,
	output logic s2_rx_data, s2_write_en, s2_read_en,
	output logic s3_master_valid, s3_master_ready, s3_rx_address,
	output logic s3_rx_data, s3_write_en, s3_read_en
);

	slave_sel_t bus_sel;
	logic [5:0] bus_fwd; // valid, ready, address, data, write, read
	logic [2:0] hit;
	logic [2:0] ret; // slave ready, valid, data

	bus_arbiter i_bus_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.m1_request(m1_request),
		.m2_request(m2_request),
		.m1_trans_done(m1_trans_done),
		.m2_trans_done(m2_trans_done),
		.m1_grant(m1_grant),
		.m2_grant(m2_grant)
	);

	// owner's lines, all zero with no owner
	assign {bus_sel, bus_fwd} =
		m1_grant ? {m1_slave_sel, m1_master_valid, m1_master_ready, m1_tx_address,
			m1_tx_data, m1_write_en, m1_read_en} :
		m2_grant ? {m2_slave_sel, m2_master_valid, m2_master_ready, m2_tx_address,
			m2_tx_data, m2_write_en, m2_read_en} :
		'0;

	assign hit = 3'b001 << bus_sel; // select 3 hits nothing

	assign {s1_master_valid, s1_master_ready, s1_rx_address, s1_rx_data, s1_write_en,
		s1_read_en} = {6{hit[0]}} & bus_fwd;
	assign {s2_master_valid, s2_master_ready, s2_rx_address, s2_rx_data, s2_write_en,
		s2_read_en} = {6{hit[1]}} & bus_fwd;
	assign {s3_master_valid, s3_master_ready, s3_rx_address, s3_rx_data, s3_write_en,
		s3_read_en} = {6{hit[2]}} & bus_fwd;

	// return path from the selected slave
	always_comb begin
		case (bus_sel)
			2'd0: ret = {s1_slave_ready, s1_slave_valid, s1_tx_data};
			2'd1: ret = {s2_slave_ready, s2_slave_valid, s2_tx_data};
			2'd2: ret = {s3_slave_ready, s3_slave_valid, s3_tx_data};
			default: ret = '0;
		endcase
	end

	assign {m1_slave_ready, m1_slave_valid, m1_rx_data} = m1_grant ? ret : '0;
	assign {m2_slave_ready, m2_slave_valid, m2_rx_data} = m2_grant ? ret : '0;

endmodule

`default_nettype wire

// File: hdl/bus_master.sv
// bus master
// latches a parallel command, waits for the bus grant and shifts the frame
// to the selected slave, then collects read data serially

`timescale 1ns/1ns
`default_nettype none

module bus_master import bus_pkg::*; #(
	parameter int ADDR_LEN = 12,
	parameter int DATA_LEN = 8
) (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire write,
	input wire slave_sel_t sel,
	input wire addr_t addr,
	input wire data_t wdata,
	input wire grant,
	input wire slave_ready,
	input wire slave_valid,
	input wire rx_data,
	output data_t rdata,
	output logic done,
	output logic busy,
	output logic request,
	output slave_sel_t slave_sel,
	output logic master_valid,
	output logic master_ready,
	output logic tx_address,
	output logic tx_data,
	output logic write_en,
	output logic read_en,
	output logic trans_done
);

	localparam int CNT_W = $clog2(ADDR_LEN); // address frame is the longest

	master_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	addr_t addr_sh;
	data_t data_sh;
	data_t rx_sh;
	logic cmd_write;
	logic accept;
	logic addr_shift;
	logic bit_in;

	assign accept = start && (state == s_idle || state == s_done);
	// first address bit already goes out in the cycle the slave is seen ready
	assign addr_shift = (state == s_wait_slave && grant && slave_ready) || state == s_send_addr;
	assign bit_in = slave_valid && (state == s_wait_read || state == s_recv_data);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				s_idle, s_done: state <= accept ? s_request : s_idle;
				s_request: if (grant) state <= s_wait_slave;
				s_wait_slave: begin
					if (addr_shift) begin
						state <= s_send_addr;
						bit_cnt <= CNT_W'(1);
					end
				end
				s_send_addr: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(ADDR_LEN - 1)) begin
						bit_cnt <= '0;
						state <= cmd_write ? s_send_data : s_wait_read;
					end
				end
				s_send_data: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(DATA_LEN - 1)) state <= s_done;
				end
				s_wait_read: begin
					if (slave_valid) begin
						state <= s_recv_data;
						bit_cnt <= CNT_W'(1);
					end
				end
				s_recv_data: begin
					if (slave_valid) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(DATA_LEN - 1)) state <= s_done;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// command and shift registers
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_sh <= addr;
			data_sh <= wdata;
			cmd_write <= write;
			slave_sel <= sel;
		end else begin
			if (addr_shift) addr_sh <= addr_sh >> 1; // lsb first
			if (state == s_send_data) data_sh <= data_sh >> 1;
		end
		if (bit_in) rx_sh <= {rx_data, rx_sh[DATA_LEN-1:1]};
		if (bit_in && state == s_recv_data && bit_cnt == CNT_W'(DATA_LEN - 1))
			rdata <= {rx_data, rx_sh[DATA_LEN-1:1]}; // held until the next read ends
	end

	assign busy = state != s_idle && state != s_done;
	assign request = busy;
	assign done = (state == s_done);
	assign trans_done = done; // same event, bus side

	assign master_valid = addr_shift || state == s_send_data;
	assign master_ready = (state == s_wait_read || state == s_recv_data);
	assign tx_address = addr_sh[0];
	assign tx_data = data_sh[0];

	// direction levels while on the bus
	assign write_en = busy && state != s_request && cmd_write;
	assign read_en = busy && state != s_request && !cmd_write;

endmodule

`default_nettype wire

// File: hdl/bus_pkg.sv
// bus package
// frame widths, vector types and the master FSM states shared by the serial bus

`default_nettype none

package bus_pkg;

	localparam int ADDR_LEN = 12; // address bits per serial frame
	localparam int DATA_LEN = 8;
	localparam int SLAVE_LEN = 2;

	typedef logic [ADDR_LEN-1:0] addr_t; // byte address inside one slave
	typedef logic [DATA_LEN-1:0] data_t;
	typedef logic [SLAVE_LEN-1:0] slave_sel_t; // 0..2 pick slave 1..3

	// master FSM
	typedef enum logic [2:0] {
		s_idle,
		s_request,
		s_wait_slave,
		s_send_addr,
		s_send_data,
		s_wait_read,
		s_recv_data,
		s_done
	} master_state_t;

endpackage

`default_nettype wire

// File: hdl/bus_top.sv
// serial bus system top
// two masters share one serial bus to a 4k and two 2k memory slaves

`timescale 1ns/1ns
`default_nettype none

module bus_top import bus_pkg::*; #(
	parameter int ADDR_LEN = 12,
	parameter int DATA_LEN = 8,
	parameter int S1_ADDR_BITS = 12,
	parameter int S2_ADDR_BITS = 11,
	parameter int S3_ADDR_BITS = 11,
	parameter int S1_DELAY = 0,
	parameter int S2_DELAY = 0,
	parameter int S3_DELAY = 10
) (
	input wire clk,
	input wire rst_n,
	input wire m1_start, m1_write,
	input wire slave_sel_t m1_sel,
	input wire addr_t m1_addr,
	input wire data_t m1_wdata,
	input wire m2_start, m2_write,
	input wire slave_sel_t m2_sel,
	input wire addr_t m2_addr,
	input wire data_t m2_wdata,
	output data_t m1_rdata,
	output logic m1_done, m1_busy,
	output data_t m2_rdata,
	output logic m2_done, m2_busy
);

	slave_sel_t m1_slave_sel, m2_slave_sel;
	logic m1_request, m1_grant, m1_master_valid, m1_master_ready, m1_trans_done;
	logic m1_tx_address, m1_tx_data, m1_write_en, m1_read_en;
	logic m1_slave_ready, m1_slave_valid, m1_rx_data;
	logic m2_request, m2_grant, m2_master_valid, m2_master_ready, m2_trans_done;
	logic m2_tx_address, m2_tx_data, m2_write_en, m2_read_en;
	logic m2_slave_ready, m2_slave_valid, m2_rx_data;
	logic s1_master_valid, s1_master_ready, s1_rx_address, s1_rx_data, s1_write_en, s1_read_en;
	logic s2_master_valid, s2_master_ready, s2_rx_address, s2_rx_data, s2_write_en, s2_read_en;
	logic s3_master_valid, s3_master_ready, s3_rx_address, s3_rx_data, s3_write_en, s3_read_en;
	logic s1_slave_ready, s1_slave_valid, s1_tx_data;
	logic s2_slave_ready, s2_slave_valid, s2_tx_data;
	logic s3_slave_ready, s3_slave_valid, s3_tx_data;

	bus_master #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN)) i_master1 (
		.clk(clk), .rst_n(rst_n), .start(m1_start), .write(m1_write),
		.sel(m1_sel), .addr(m1_addr), .wdata(m1_wdata),
		.grant(m1_grant), .slave_ready(m1_slave_ready), .slave_valid(m1_slave_valid),
		.rx_data(m1_rx_data), .rdata(m1_rdata), .done(m1_done), .busy(m1_busy),
		.request(m1_request), .slave_sel(m1_slave_sel),
		.master_valid(m1_master_valid), .master_ready(m1_master_ready),
		.tx_address(m1_tx_address), .tx_data(m1_tx_data),
		.write_en(m1_write_en), .read_en(m1_read_en), .trans_done(m1_trans_done)
	);

	bus_master #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN)) i_master2 (
		.clk(clk), .rst_n(rst_n), .start(m2_start), .write(m2_write),
		.sel(m2_sel), .addr(m2_addr), .wdata(m2_wdata),
		.grant(m2_grant), .slave_ready(m2_slave_ready), .slave_valid(m2_slave_valid),
		.rx_data(m2_rx_data), .rdata(m2_rdata), .done(m2_done), .busy(m2_busy),
		.request(m2_request), .slave_sel(m2_slave_sel),
		.master_valid(m2_master_valid), .master_ready(m2_master_ready),
		.tx_address(m2_tx_address), .tx_data(m2_tx_data),
		.write_en(m2_write_en), .read_en(m2_read_en), .trans_done(m2_trans_done)
	);

	bus_interconnect i_interconnect (
		.clk(clk), .rst_n(rst_n),
		.m1_request(m1_request), .m1_master_valid(m1_master_valid),
		.m1_master_ready(m1_master_ready), .m1_trans_done(m1_trans_done),
		.m1_tx_address(m1_tx_address), .m1_tx_data(m1_tx_data),
		.m1_write_en(m1_write_en), .m1_read_en(m1_read_en), .m1_slave_sel(m1_slave_sel),
		.m2_request(m2_request), .m2_master_valid(m2_master_valid),
		.m2_master_ready(m2_master_ready), .m2_trans_done(m2_trans_done),
		.m2_tx_address(m2_tx_address), .m2_tx_data(m2_tx_data),
		.m2_write_en(m2_write_en), .m2_read_en(m2_read_en), .m2_slave_sel(m2_slave_sel),
		.s1_slave_ready(s1_slave_ready), .s1_slave_valid(s1_slave_valid),
		.s1_tx_data(s1_tx_data),
		.s2_slave_ready(s2_slave_ready), .s2_slave_valid(s2_slave_valid),
		.s2_tx_data(s2_tx_data),
		.s3_slave_ready(s3_slave_ready), .s3_slave_valid(s3_slave_valid),
		.s3_tx_data(s3_tx_data),
		.m1_grant(m1_grant), .m2_grant(m2_grant),
		.m1_slave_ready(m1_slave_ready), .m1_slave_valid(m1_slave_valid),
		.m1_rx_data(m1_rx_data),
		.m2_slave_ready(m2_slave_ready), .m2_slave_valid(m2_slave_valid),
		.m2_rx_data(m2_rx_data),
		.s1_master_valid(s1_master_valid), .s1_master_ready(s1_master_ready),
		.s1_rx_address(s1_rx_address), .s1_rx_data(s1_rx_data),
		.s1_write_en(s1_write_en), .s1_read_en(s1_read_en),
		.s2_master_valid(s2_master_valid), .s2_master_ready(s2_master_ready),
		.s2_rx_address(s2_rx_address), .s2_rx_data(s2_rx_data),
		.s2_write_en(s2_write_en), .s2_read_en(s2_read_en),
		.s3_master_valid(s3_master_valid), .s3_master_ready(s3_master_ready),
		.s3_rx_address(s3_rx_address), .s3_rx_data(s3_rx_data),
		.s3_write_en(s3_write_en), .s3_read_en(s3_read_en)
	);

	// 4k slave
	slave_memory #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN),
		.MEM_ADDR_BITS(S1_ADDR_BITS), .READ_DELAY(S1_DELAY)) i_slave1 (
		.clk(clk), .rst_n(rst_n),
		.master_valid(s1_master_valid), .master_ready(s1_master_ready),
		.rx_address(s1_rx_address), .rx_data(s1_rx_data),
		.write_en(s1_write_en), .read_en(s1_read_en),
		.slave_ready(s1_slave_ready), .slave_valid(s1_slave_valid), .tx_data(s1_tx_data)
	);

	slave_memory #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN),
		.MEM_ADDR_BITS(S2_ADDR_BITS), .READ_DELAY(S2_DELAY)) i_slave2 (
		.clk(clk), .rst_n(rst_n),
		.master_valid(s2_master_valid), .master_ready(s2_master_ready),
		.rx_address(s2_rx_address), .rx_data(s2_rx_data),
		.write_en(s2_write_en), .read_en(s2_read_en),
		.slave_ready(s2_slave_ready), .slave_valid(s2_slave_valid), .tx_data(s2_tx_data)
	);

	// slow 2k slave
	slave_memory #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN),
		.MEM_ADDR_BITS(S3_ADDR_BITS), .READ_DELAY(S3_DELAY)) i_slave3 (
		.clk(clk), .rst_n(rst_n),
		.master_valid(s3_master_valid), .master_ready(s3_master_ready),
		.rx_address(s3_rx_address), .rx_data(s3_rx_data),
		.write_en(s3_write_en), .read_en(s3_read_en),
		.slave_ready(s3_slave_ready), .slave_valid(s3_slave_valid), .tx_data(s3_tx_data)
	);

endmodule

`default_nettype wire

// File: hdl/slave_memory.sv
// serial memory slave
// collects an address frame, then stores a serial byte or answers a read
// after a fixed delay; only the low MEM_ADDR_BITS address bits index the array

`timescale 1ns/1ns
`default_nettype none

module slave_memory #(
	parameter int ADDR_LEN = 12,
	parameter int DATA_LEN = 8,
	parameter int MEM_ADDR_BITS = 12,
	parameter int READ_DELAY = 0
) (
	input wire clk,
	input wire rst_n,
	input wire master_valid,
	input wire master_ready,
	input wire rx_address,
	input wire rx_data,
	input wire write_en,
	input wire read_en,
	output logic slave_ready,
	output logic slave_valid,
	output logic tx_data
);

	localparam int CNT_W = $clog2(ADDR_LEN);
	localparam int IDX_W = $clog2(DATA_LEN);
	localparam int DLY_W = (READ_DELAY > 0) ? $clog2(READ_DELAY + 1) : 1;

	typedef enum logic [2:0] {
		sl_idle,
		sl_addr,
		sl_data,
		sl_delay,
		sl_send
	} slave_state_t;

	slave_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic [DLY_W-1:0] dly_cnt;
	logic is_write;
	logic frame_start;
	logic [ADDR_LEN-1:0] addr_sh;
	logic [DATA_LEN-1:0] data_sh;
	logic [DATA_LEN-1:0] rd_byte;
	logic [DATA_LEN-1:0] mem [2**MEM_ADDR_BITS];

	assign frame_start = state == sl_idle && master_valid && (write_en || read_en);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= sl_idle;
			bit_cnt <= '0;
			dly_cnt <= '0;
			is_write <= 1'b0;
		end else begin
			case (state)
				sl_idle: begin
					if (frame_start) begin
						state <= sl_addr; // bit 0 taken here
						bit_cnt <= CNT_W'(1);
						is_write <= write_en;
					end
				end
				sl_addr: begin
					if (master_valid) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(ADDR_LEN - 1)) begin
							bit_cnt <= '0;
							dly_cnt <= DLY_W'(READ_DELAY - 1);
							if (is_write)
								state <= sl_data;
							else
								state <= (READ_DELAY == 0) ? sl_send : sl_delay;
						end
					end
				end
				sl_data: begin
					if (master_valid) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(DATA_LEN - 1)) state <= sl_idle;
					end
				end
				sl_delay: begin
					dly_cnt <= dly_cnt - 1'b1;
					if (dly_cnt == '0) state <= sl_send;
				end
				sl_send: begin
					if (master_ready) begin // stall keeps the current bit
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(DATA_LEN - 1)) state <= sl_idle;
					end
				end
				default: state <= sl_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start || (state == sl_addr && master_valid))
			addr_sh <= {rx_address, addr_sh[ADDR_LEN-1:1]};
		if (state == sl_data && master_valid) begin
			data_sh <= {rx_data, data_sh[DATA_LEN-1:1]};
			if (bit_cnt == CNT_W'(DATA_LEN - 1))
				mem[addr_sh[MEM_ADDR_BITS-1:0]] <= {rx_data, data_sh[DATA_LEN-1:1]};
		end
	end

	assign rd_byte = mem[addr_sh[MEM_ADDR_BITS-1:0]]; // upper bits alias
	assign slave_ready = (state == sl_idle);
	assign slave_valid = (state == sl_send) && master_ready;
	assign tx_data = rd_byte[bit_cnt[IDX_W-1:0]];

endmodule

`default_nettype wire

// File: tb.f
hdl/bus_pkg.sv
hdl/bus_master.sv
hdl/bus_arbiter.sv
hdl/bus_interconnect.sv
hdl/slave_memory.sv
hdl/bus_top.sv
testbench/bus_properties.sv
testbench/tb_bus_top.sv

// File: testbench/bus_properties.sv
// arbiter properties
// grant exclusivity, grant hold until done, done pulse width, grant only on request

`timescale 1ns/1ns
`default_nettype none

module bus_properties (
	input wire clk,
	input wire rst_n,
	input wire m1_request,
	input wire m2_request,
	input wire m1_trans_done,
	input wire m2_trans_done,
	input wire m1_grant,
	input wire m2_grant
);

	grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(m1_grant && m2_grant)) else $error("both grants high");

	// owner keeps the bus until its own done
	m1_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
		m1_grant && !m1_trans_done |=> m1_grant) else $error("master 1 grant dropped early");
	m2_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
		m2_grant && !m2_trans_done |=> m2_grant) else $error("master 2 grant dropped early");

	m1_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		m1_trans_done |=> !m1_trans_done) else $error("master 1 done longer than one cycle");
	m2_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		m2_trans_done |=> !m2_trans_done) else $error("master 2 done longer than one cycle");

	// request falls with done, grant one cycle later
	m1_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
		m1_grant |-> m1_request || m1_trans_done) else $error("master 1 granted, no request");
	m2_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
		m2_grant |-> m2_request || m2_trans_done) else $error("master 2 granted, no request");

endmodule

`default_nettype wire

// File: testbench/tb_bus_top.sv
// testbench for the serial bus system
// directed tests of both masters against a byte-array model of the three slaves

`timescale 1ns/1ns
`default_nettype none

module tb_bus_top import bus_pkg::*; ();

	localparam int NUM_CMDS = 54; // commands issued by all tests together
	localparam int CMD_CYCLES = 200;
	localparam int DONE_LIMIT = 400;
	localparam logic [31:0] SEED = 32'hc54ead98;

	logic clk;
	logic rst_n;
	logic m1_start, m1_write, m2_start, m2_write;
	slave_sel_t m1_sel, m2_sel;
	addr_t m1_addr, m2_addr;
	data_t m1_wdata, m2_wdata;
	data_t m1_rdata, m2_rdata;
	logic m1_done, m1_busy, m2_done, m2_busy;

	data_t model [3][4096]; // one byte array per slave
	logic [13:0] written [$]; // {sel, addr} of every write so far
	int errors;
	int checks;
	int cyc = 0;

	bus_top i_bus_top (
		.clk(clk), .rst_n(rst_n),
		.m1_start(m1_start), .m1_write(m1_write), .m1_sel(m1_sel),
		.m1_addr(m1_addr), .m1_wdata(m1_wdata),
		.m2_start(m2_start), .m2_write(m2_write), .m2_sel(m2_sel),
		.m2_addr(m2_addr), .m2_wdata(m2_wdata),
		.m1_rdata(m1_rdata), .m1_done(m1_done), .m1_busy(m1_busy),
		.m2_rdata(m2_rdata), .m2_done(m2_done), .m2_busy(m2_busy)
	);

	bind bus_arbiter bus_properties i_bus_properties (
		.clk(clk), .rst_n(rst_n),
		.m1_request(m1_request), .m2_request(m2_request),
		.m1_trans_done(m1_trans_done), .m2_trans_done(m2_trans_done),
		.m1_grant(m1_grant), .m2_grant(m2_grant)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1; // timestamps for done pulses

	// slave 1 is 4k while slaves 2 and 3 are 2k and alias above that
	function automatic int depth_of(input slave_sel_t sel);
		return (sel == 2'd0) ? 4096 : 2048;
	endfunction

	function automatic data_t model_read(input slave_sel_t sel, input addr_t a);
		return model[sel][int'(a) % depth_of(sel)];
	endfunction

	task automatic model_write(input slave_sel_t sel, input addr_t a, input data_t d);
		model[sel][int'(a) % depth_of(sel)] = d;
		written.push_back({sel, a});
	endtask

	task automatic check_byte(input string name, input data_t exp, input data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic next_edge();
		@(posedge clk);
		#2; // inputs change just after the edge
	endtask

	task automatic issue(input int m, input logic wr, input slave_sel_t sel,
		input addr_t a, input data_t d);
		if (m == 1) begin
			m1_start = 1'b1;
			m1_write = wr;
			m1_sel = sel;
			m1_addr = a;
			m1_wdata = d;
		end else begin
			m2_start = 1'b1;
			m2_write = wr;
			m2_sel = sel;
			m2_addr = a;
			m2_wdata = d;
		end
	endtask

	task automatic drop_starts();
		m1_start = 1'b0;
		m2_start = 1'b0;
	endtask

	// done, busy and rdata sampled on the falling edge
	task automatic wait_done(input int m, output int stamp, output data_t rd);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		stamp = -1;
		rd = '0;
		while (!seen && n < DONE_LIMIT) begin
			@(negedge clk);
			n++;
			if ((m == 1 && m1_done) || (m == 2 && m2_done)) begin
				seen = 1'b1;
				stamp = cyc;
				rd = (m == 1) ? m1_rdata : m2_rdata;
				checks++;
				if ((m == 1 && m1_busy) || (m == 2 && m2_busy)) begin
					errors++;
					$display("master %0d still busy in the cycle of its done pulse", m);
				end
			end
		end
		if (!seen) begin
			errors++;
			$display("master %0d gave no done pulse within %0d cycles", m, DONE_LIMIT);
		end
	endtask

	task automatic run_cmd(input string name, input int m, input logic wr,
		input slave_sel_t sel, input addr_t a, input data_t d);
		int stamp;
		data_t rd;
		data_t exp;
		exp = model_read(sel, a);
		if (wr)
			model_write(sel, a, d);
		next_edge();
		issue(m, wr, sel, a, d);
		next_edge();
		drop_starts();
		wait_done(m, stamp, rd);
		if (!wr && stamp >= 0)
			check_byte(name, exp, rd);
	endtask

	task automatic test_reset_idle();
		repeat (8) begin
			@(negedge clk);
			checks++;
			if (m1_busy || m1_done || m2_busy || m2_done) begin
				errors++;
				$display("test_reset_idle: busy or done went high with no command");
			end
		end
	endtask

	task automatic test_single_rw();
		addr_t a;
		data_t d;
		for (int s = 0; s < 3; s++) begin
			a = addr_t'($urandom());
			d = data_t'($urandom());
			run_cmd("test_single_rw", 1, 1'b1, slave_sel_t'(s), a, d);
			run_cmd("test_single_rw", 1, 1'b0, slave_sel_t'(s), a, 8'h00);
		end
	endtask

	task automatic test_alias();
		addr_t a;
		data_t d;
		a = addr_t'($urandom_range(0, 2047));
		d = data_t'($urandom());
		run_cmd("test_alias", 2, 1'b1, 2'd1, a + 12'd2048, d);
		run_cmd("test_alias", 2, 1'b0, 2'd1, a, 8'h00); // low 11 bits only
	endtask

	task automatic test_priority();
		addr_t a1, a2;
		data_t d1, d2, r1, r2;
		int t1, t2;
		a1 = addr_t'($urandom());
		a2 = addr_t'($urandom());
		d1 = data_t'($urandom());
		d2 = data_t'($urandom());
		model_write(2'd0, a1, d1);
		model_write(2'd2, a2, d2);
		next_edge();
		issue(1, 1'b1, 2'd0, a1, d1);
		issue(2, 1'b1, 2'd2, a2, d2);
		next_edge();
		drop_starts();
		@(negedge clk);
		checks++;
		if (!m1_busy || !m2_busy) begin
			errors++;
			$display("test_priority: a master with a pending command is not busy");
		end
		fork
			wait_done(1, t1, r1);
			wait_done(2, t2, r2);
		join
		checks++;
		if (t1 < 0 || t2 < 0 || t1 >= t2) begin
			errors++;
			$display("test_priority: master 1 done at cycle %0d, master 2 done at cycle %0d",
				t1, t2);
		end
		// read back each write through the other master
		run_cmd("test_priority", 2, 1'b0, 2'd0, a1, 8'h00);
		run_cmd("test_priority", 1, 1'b0, 2'd2, a2, 8'h00);
	endtask

	task automatic test_same_addr();
		addr_t a;
		data_t d, r1, r2;
		int t1, t2;
		a = addr_t'($urandom());
		d = data_t'($urandom());
		model_write(2'd2, a, d); // master 1 goes first
		next_edge();
		issue(1, 1'b1, 2'd2, a, d);
		issue(2, 1'b0, 2'd2, a, 8'h00);
		next_edge();
		drop_starts();
		fork
			wait_done(1, t1, r1);
			wait_done(2, t2, r2);
		join
		if (t2 >= 0)
			check_byte("test_same_addr", model_read(2'd2, a), r2);
	endtask

	task automatic test_random();
		int m;
		logic [13:0] key;
		for (int i = 0; i < 40; i++) begin
			m = (i % 2) + 1;
			if (written.size() == 0 || $urandom_range(0, 1) == 0) begin
				run_cmd("test_random", m, 1'b1, slave_sel_t'(i % 3),
					addr_t'($urandom()), data_t'($urandom()));
			end else begin
				key = written[$urandom_range(0, written.size() - 1)];
				run_cmd("test_random", m, 1'b0, key[13:12], key[11:0], 8'h00);
			end
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		void'($urandom(SEED));
		rst_n = 1'b0;
		m1_start = 1'b0;
		m1_write = 1'b0;
		m1_sel = '0;
		m1_addr = '0;
		m1_wdata = '0;
		m2_start = 1'b0;
		m2_write = 1'b0;
		m2_sel = '0;
		m2_addr = '0;
		m2_wdata = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		test_reset_idle();
		test_single_rw();
		test_alias();
		test_priority();
		test_same_addr();
		test_random();
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (16 + NUM_CMDS * CMD_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish",
			16 + NUM_CMDS * CMD_CYCLES);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
